//--- src/br_tag_cfg.svh
// ##########################################################
// Sizing macros for the branch tag unit and its Wishbone port
// ##########################################################
`ifndef BR_TAG_CFG_SVH
`define BR_TAG_CFG_SVH

// One mask bit per in-flight branch
`define BR_MASK_W 5

// Opaque rename snapshot word from the dispatcher
`define SNAP_W 8

// Wishbone word address and data widths
`define WB_ADR_W 5
`define WB_DAT_W 32

// Event counter width, counters saturate
`define CNT_W 16

`endif

//--- src/br_tag_pkg.sv
// ##########################################################
// Shared types and the lowest-zero helper for the tag unit
// ##########################################################
`default_nettype none
`include "br_tag_cfg.svh"

package br_tag_pkg;

  // Resolution reported by the ROB for one branch
  typedef enum logic [1:0] {
    BR_NONE    = 2'd0,
    BR_CORRECT = 2'd1,
    BR_WRONG   = 2'd2
  } br_state_e;

  // Register map in word addresses
  typedef enum logic [`WB_ADR_W-1:0] {
    REG_STATUS       = `WB_ADR_W'd0, // Mask low bits, full at bit 8
    REG_DISPATCH_CNT = `WB_ADR_W'd1,
    REG_CORRECT_CNT  = `WB_ADR_W'd2,
    REG_WRONG_CNT    = `WB_ADR_W'd3,
    REG_REFUSED_CNT  = `WB_ADR_W'd4,
    REG_CTRL         = `WB_ADR_W'd5  // Bit 0 written as 1 clears counters
  } reg_addr_e;

  // One-hot of the lowest clear bit, zero when the mask is all ones
  function automatic logic [`BR_MASK_W-1:0] lowest_zero(input logic [`BR_MASK_W-1:0] m);
    return ~m & (m + 1'b1); // Carry stops at the first zero, wraps to 0 when full
  endfunction

endpackage

`default_nettype wire

//--- src/br_tag_if.sv
// ##########################################################
// Per-cycle tag events from the mask controller
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

interface br_tag_if;

  logic                  alloc;       // Dispatch accepted this cycle
  logic [`BR_MASK_W-1:0] alloc_bit;   // Granted tag, one-hot
  logic                  refused;     // Dispatch hit a full mask
  logic                  resolve;     // Correct or wrong resolution present
  logic                  wrong;       // Qualifies resolve as a misprediction
  logic [`BR_MASK_W-1:0] resolve_bit; // Tag of the resolving branch
  logic [`BR_MASK_W-1:0] mask;        // Registered live mask
  logic                  full;        // All tags in use

  // Mask controller drives every event
  modport ctrl (
    output alloc, alloc_bit, refused, resolve, wrong, resolve_bit, mask, full
  );

  // Snapshot store needs the grant and the resolving tag
  modport store (
    input alloc, alloc_bit, resolve, wrong, resolve_bit
  );

  // Register block counts events and reports status
  modport regs (
    input alloc, refused, resolve, wrong, mask, full
  );

endinterface

`default_nettype wire

//--- src/br_mask_ctrl.sv
// ##########################################################
// Branch mask register with allocate, clear and restore rules
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

module br_mask_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  is_br_i,       // Dispatch strobe, no ready
  input  br_tag_pkg::br_state_e br_state_i,    // Resolution from the ROB
  input  logic [`BR_MASK_W-1:0] br_dep_mask_i, // Dependency mask of resolving branch
  output logic [`BR_MASK_W-1:0] br_mask_o,
  output logic [`BR_MASK_W-1:0] br_bit_o,
  output logic                  full_o,
  br_tag_if.ctrl                tag
);

  import br_tag_pkg::*;

  logic [`BR_MASK_W-1:0] mask;      // Live tag mask
  logic [`BR_MASK_W-1:0] next_mask;
  logic [`BR_MASK_W-1:0] res_bit;   // Tag being resolved
  logic [`BR_MASK_W-1:0] cleared;   // Mask after a correct resolution
  logic [`BR_MASK_W-1:0] grant;     // Tag handed to a new dispatch
  logic                  is_correct;
  logic                  is_wrong;
  logic                  dispatch;  // Dispatch that is not overridden
  logic                  full;

  assign is_correct = (br_state_i == BR_CORRECT);
  assign is_wrong   = (br_state_i == BR_WRONG);

  // A branch's own tag is the first zero of the mask it was dispatched under
  assign res_bit = (is_correct || is_wrong) ? lowest_zero(br_dep_mask_i) : '0;

  // Free the resolved tag before looking for a new one
  assign cleared = is_correct ? (mask & ~res_bit) : mask;

  // Dispatch is dropped during a misprediction
  assign dispatch = is_br_i & ~is_wrong;
  assign grant    = dispatch ? lowest_zero(cleared) : '0;

  always_comb begin
    if (is_wrong) begin
      next_mask = br_dep_mask_i; // Roll back to the branch's view
    end else begin
      next_mask = cleared | grant;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mask <= '0;
    end else begin
      mask <= next_mask;
    end
  end

  assign full = &mask;

  assign br_mask_o = mask;
  assign br_bit_o  = res_bit; // Same cycle, the RS needs it immediately
  assign full_o    = full;

  // Events travel with the update they describe
  assign tag.alloc       = |grant;
  assign tag.alloc_bit   = grant;
  assign tag.refused     = dispatch & ~|grant; // Still full after any clear
  assign tag.resolve     = is_correct | is_wrong;
  assign tag.wrong       = is_wrong;
  assign tag.resolve_bit = res_bit;
  assign tag.mask        = mask;
  assign tag.full        = full;

  // Outside a rollback at most one new tag appears per cycle
  a_one_new_bit: assert property (@(posedge clk) disable iff (rst)
    !is_wrong |=> $countones(mask & ~$past(mask)) <= 1);

  // Snapshot store relies on no write during a recovery read
  a_wrong_no_alloc: assert property (@(posedge clk) disable iff (rst)
    (tag.resolve && tag.wrong) |-> !tag.alloc);

endmodule

`default_nettype wire

//--- src/br_checkpoint_store.sv
// ##########################################################
// Per-tag rename snapshots, read out on a misprediction
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

module br_checkpoint_store (
  input  logic               clk,
  input  logic               rst,
  input  logic [`SNAP_W-1:0] snap_i,          // Snapshot offered with each dispatch
  output logic               recover_valid_o, // One-cycle pulse after a wrong resolution
  output logic [`SNAP_W-1:0] recover_snap_o,
  br_tag_if.store            tag
);

  logic [`SNAP_W-1:0] snap_mem [`BR_MASK_W]; // One slot per tag
  logic [`SNAP_W-1:0] rd_snap;
  logic               recover;

  assign recover = tag.resolve & tag.wrong;

  // Slot selected by the granted one-hot tag
  always_ff @(posedge clk) begin
    for (int i = 0; i < `BR_MASK_W; i++) begin
      if (tag.alloc && tag.alloc_bit[i]) begin
        snap_mem[i] <= snap_i;
      end
    end
  end

  // One-hot read mux, OR of the selected slots
  always_comb begin
    rd_snap = '0;
    for (int i = 0; i < `BR_MASK_W; i++) begin
      if (tag.resolve_bit[i]) begin
        rd_snap = rd_snap | snap_mem[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      recover_valid_o <= 1'b0;
    end else begin
      recover_valid_o <= recover; // Drops again the following cycle
    end
  end

  // Data only loads on a recovery, valid qualifies it
  always_ff @(posedge clk) begin
    if (recover) begin
      recover_snap_o <= rd_snap;
    end
  end

  // The OR mux above is only correct for a single selected slot
  a_resolve_onehot: assert property (@(posedge clk) disable iff (rst)
    tag.resolve |-> $onehot0(tag.resolve_bit));

endmodule

`default_nettype wire

//--- src/br_tag_regs.sv
// ##########################################################
// Wishbone classic slave with event counters and status
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

module br_tag_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`WB_ADR_W-1:0] wb_adr_i, // Word address
  input  logic [`WB_DAT_W-1:0] wb_dat_i,
  output logic [`WB_DAT_W-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  br_tag_if.regs               tag
);

  import br_tag_pkg::*;

  localparam int NUM_CNT = 4;
  localparam int FULL_BIT = 8; // Full flag position in STATUS

  // Counter index 0 dispatch, 1 correct, 2 wrong, 3 refused
  logic [`CNT_W-1:0]    cnt [NUM_CNT];
  logic [NUM_CNT-1:0]   evt;
  logic                 req;     // New request, first clock of a cycle
  logic                 wr_en;
  logic                 clr;
  reg_addr_e            addr;
  logic [`WB_DAT_W-1:0] rd_data;

  // Ack high blocks a second request edge, so each cycle is two clocks
  assign req   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en = req & wb_we_i;
  assign addr  = reg_addr_e'(wb_adr_i);

  // Clear lands on the edge that raises ack
  assign clr = wr_en && (addr == REG_CTRL) && wb_dat_i[0];

  assign evt[0] = tag.alloc;
  assign evt[1] = tag.resolve & ~tag.wrong;
  assign evt[2] = tag.resolve & tag.wrong;
  assign evt[3] = tag.refused;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt[i] <= '0;
      end
    end else if (clr) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt[i] <= '0; // Clear wins over a same-cycle event
      end
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        if (evt[i] && !(&cnt[i])) begin
          cnt[i] <= cnt[i] + 1'b1; // Hold at all ones
        end
      end
    end
  end

  // Read decode
  always_comb begin
    rd_data = '0;
    case (addr)
      REG_STATUS: begin
        rd_data[`BR_MASK_W-1:0] = tag.mask;
        rd_data[FULL_BIT]       = tag.full;
      end
      REG_DISPATCH_CNT: rd_data[`CNT_W-1:0] = cnt[0];
      REG_CORRECT_CNT:  rd_data[`CNT_W-1:0] = cnt[1];
      REG_WRONG_CNT:    rd_data[`CNT_W-1:0] = cnt[2];
      REG_REFUSED_CNT:  rd_data[`CNT_W-1:0] = cnt[3];
      default:          rd_data = '0; // CTRL reads back zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  // Read data captured with the request, stable while ack is high
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  // Host sees exactly one ack per cycle even if stb stays high
  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

//--- src/br_tag_unit.sv
// ##########################################################
// Branch tag unit top, mask, snapshots and host registers
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

module br_tag_unit (
  input  logic                  clk,
  input  logic                  rst,
  // Dispatch side
  input  logic                  dispatch_br_i,
  input  logic [`SNAP_W-1:0]    dispatch_snap_i,
  // Resolution from the ROB
  input  br_tag_pkg::br_state_e resolve_state_i,
  input  logic [`BR_MASK_W-1:0] resolve_dep_mask_i,
  // Mask status
  output logic [`BR_MASK_W-1:0] br_mask_o,
  output logic [`BR_MASK_W-1:0] br_bit_o,
  output logic                  full_o,
  // Rename recovery
  output logic                  recover_valid_o,
  output logic [`SNAP_W-1:0]    recover_snap_o,
  // Host Wishbone
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`WB_ADR_W-1:0]  wb_adr_i,
  input  logic [`WB_DAT_W-1:0]  wb_dat_i,
  output logic [`WB_DAT_W-1:0]  wb_dat_o,
  output logic                  wb_ack_o
);

  br_tag_if tag_bus (); // Shared event bus

  br_mask_ctrl u_mask_ctrl (
    .clk           (clk),
    .rst           (rst),
    .is_br_i       (dispatch_br_i),
    .br_state_i    (resolve_state_i),
    .br_dep_mask_i (resolve_dep_mask_i),
    .br_mask_o     (br_mask_o),
    .br_bit_o      (br_bit_o),
    .full_o        (full_o),
    .tag           (tag_bus.ctrl)
  );

  br_checkpoint_store u_ckpt (
    .clk             (clk),
    .rst             (rst),
    .snap_i          (dispatch_snap_i),
    .recover_valid_o (recover_valid_o),
    .recover_snap_o  (recover_snap_o),
    .tag             (tag_bus.store)
  );

  br_tag_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .tag      (tag_bus.regs)
  );

endmodule

`default_nettype wire

//--- tb/br_tag_checker.sv
// ##########################################################
// Reference model of mask, snapshots and counters, compares uut
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

module br_tag_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dispatch_br_i,
  input  logic [`SNAP_W-1:0]    dispatch_snap_i,
  input  br_tag_pkg::br_state_e resolve_state_i,
  input  logic [`BR_MASK_W-1:0] resolve_dep_mask_i,
  input  logic [`BR_MASK_W-1:0] br_mask_i,
  input  logic [`BR_MASK_W-1:0] br_bit_i,
  input  logic                  full_i,
  input  logic                  recover_valid_i,
  input  logic [`SNAP_W-1:0]    recover_snap_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`WB_ADR_W-1:0]  wb_adr_i,
  input  logic [`WB_DAT_W-1:0]  wb_dat_i,
  input  logic                  wb_ack_i
);

  import br_tag_pkg::*;

  logic [`BR_MASK_W-1:0] m_mask;                // Model of the live mask
  logic [`SNAP_W-1:0]    m_snap [`BR_MASK_W];   // Snapshot per tag
  logic [`BR_MASK_W-1:0] rec_dep [`BR_MASK_W];  // Dependency mask seen at dispatch
  logic [`BR_MASK_W-1:0] rec_valid;             // Tags the testbench may resolve
  int                    m_cnt [4];             // Dispatch, correct, wrong, refused
  logic                  m_ack;                 // Expected Wishbone ack state
  int                    err_cnt = 0;
  int                    test_err = 0;
  int                    test_cnt = 0;
  string                 cur_test = "reset";

  // Scan from the top so the last hit is the lowest free bit
  function automatic logic [`BR_MASK_W-1:0] first_free(input logic [`BR_MASK_W-1:0] m);
    logic [`BR_MASK_W-1:0] r;
    r = '0;
    for (int i = `BR_MASK_W - 1; i >= 0; i--) begin
      if (!m[i]) begin
        r    = '0;
        r[i] = 1'b1;
      end
    end
    return r;
  endfunction

  function automatic int tag_index(input logic [`BR_MASK_W-1:0] oh);
    int idx;
    idx = 0;
    for (int i = 0; i < `BR_MASK_W; i++) begin
      if (oh[i]) idx = i;
    end
    return idx;
  endfunction

  // Mask rules: rollback, clear then allocate, refuse when full
  function automatic logic [`BR_MASK_W-1:0] next_mask_ref(
    input logic [`BR_MASK_W-1:0] mask,
    input logic                  br,
    input br_state_e             st,
    input logic [`BR_MASK_W-1:0] dep
  );
    logic [`BR_MASK_W-1:0] c;
    if (st == BR_WRONG) return dep;
    c = mask;
    if (st == BR_CORRECT) c = c & ~first_free(dep);
    if (br) c = c | first_free(c); // Adds nothing when full
    return c;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("Test %s: %s (%0d mismatches)", cur_test, (test_err == 0) ? "pass" : "FAIL",
             test_err);
  endtask

  task automatic check_cnt(input string what, input int idx, input logic [31:0] act);
    check_value(what, m_cnt[idx], act);
  endtask

  task automatic check_status(input logic [31:0] act);
    logic [31:0] e;
    e = '0;
    e[`BR_MASK_W-1:0] = m_mask;
    e[8] = &m_mask;             // Full flag
    check_value("STATUS", e, act);
  endtask

  task automatic final_count();
    $display("Tests run: %0d, total mismatches: %0d", test_cnt, err_cnt);
  endtask

  always @(posedge clk) begin : compare
    logic [`BR_MASK_W-1:0] e_bit;
    logic [`BR_MASK_W-1:0] cleared;
    logic [`BR_MASK_W-1:0] grant;
    logic                  exp_rv;
    logic [`SNAP_W-1:0]    exp_snap;
    logic                  req;
    e_bit    = (resolve_state_i != BR_NONE) ? first_free(resolve_dep_mask_i) : '0;
    exp_rv   = 1'b0;
    exp_snap = '0;
    if (rst) begin
      m_mask    = '0;
      rec_valid = '0;
      m_ack     = 1'b0;
      for (int i = 0; i < 4; i++) m_cnt[i] = 0;
    end else begin
      cleared = (resolve_state_i == BR_CORRECT) ? (m_mask & ~e_bit) : m_mask;
      grant   = first_free(cleared);
      req     = wb_cyc_i & wb_stb_i & ~m_ack; // Second clock of a cycle is not a request
      m_ack   = req;
      if (resolve_state_i == BR_WRONG) begin
        exp_rv    = 1'b1;
        exp_snap  = m_snap[tag_index(e_bit)];
        rec_valid = rec_valid & resolve_dep_mask_i;
        m_cnt[2]++;
      end else if (resolve_state_i == BR_CORRECT) begin
        rec_valid[tag_index(e_bit)] = 1'b0;
        m_cnt[1]++;
      end
      if (dispatch_br_i && resolve_state_i != BR_WRONG) begin
        if (grant != '0) begin
          m_snap[tag_index(grant)]    = dispatch_snap_i;
          rec_dep[tag_index(grant)]   = cleared;
          rec_valid[tag_index(grant)] = 1'b1;
          m_cnt[0]++;
        end else begin
          m_cnt[3]++;
        end
      end
      if (req && wb_we_i && wb_adr_i == REG_CTRL && wb_dat_i[0]) begin
        for (int i = 0; i < 4; i++) m_cnt[i] = 0; // Clear beats any event
      end
      m_mask = next_mask_ref(m_mask, dispatch_br_i, resolve_state_i, resolve_dep_mask_i);
    end
    #5; // Registered outputs settled, inputs still held
    check_value("mask", m_mask, br_mask_i);
    check_value("full", &m_mask, full_i);
    check_value("br_bit", e_bit, br_bit_i);
    check_value("recover_valid", exp_rv, recover_valid_i);
    check_value("wb_ack", m_ack, wb_ack_i);
    if (exp_rv) check_value("recover_snap", exp_snap, recover_snap_i);
  end

endmodule

`default_nettype wire

//--- tb/tb_br_tag_unit.sv
// ##########################################################
// Testbench top: clock, reset, stimulus, Wishbone tasks, uut
// ##########################################################
`timescale 1ns/1ps
`default_nettype none
`include "br_tag_cfg.svh"

module tb_br_tag_unit;

  import br_tag_pkg::*;

  localparam int ACK_LIMIT = 20; // Cycles to wait for ack

  logic                  clk;
  logic                  rst;
  logic                  dispatch_br;
  logic [`SNAP_W-1:0]    dispatch_snap;
  br_state_e             resolve_state;
  logic [`BR_MASK_W-1:0] resolve_dep_mask;
  logic [`BR_MASK_W-1:0] br_mask;
  logic [`BR_MASK_W-1:0] br_bit;
  logic                  full;
  logic                  recover_valid;
  logic [`SNAP_W-1:0]    recover_snap;
  logic                  wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`WB_ADR_W-1:0]  wb_adr;
  logic [`WB_DAT_W-1:0]  wb_wdat, wb_rdat, rd;
  logic [31:0]           rng;
  int                    pick;

  always #20 clk = ~clk;

  br_tag_unit uut (
    .clk (clk), .rst (rst),
    .dispatch_br_i (dispatch_br), .dispatch_snap_i (dispatch_snap),
    .resolve_state_i (resolve_state), .resolve_dep_mask_i (resolve_dep_mask),
    .br_mask_o (br_mask), .br_bit_o (br_bit), .full_o (full),
    .recover_valid_o (recover_valid), .recover_snap_o (recover_snap),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat), .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack)
  );

  br_tag_checker chk (
    .clk (clk), .rst (rst),
    .dispatch_br_i (dispatch_br), .dispatch_snap_i (dispatch_snap),
    .resolve_state_i (resolve_state), .resolve_dep_mask_i (resolve_dep_mask),
    .br_mask_i (br_mask), .br_bit_i (br_bit), .full_i (full),
    .recover_valid_i (recover_valid), .recover_snap_i (recover_snap),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat), .wb_ack_i (wb_ack)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // One cycle of core-side inputs, applied on the falling edge
  task automatic drive_cycle(input logic br, input logic [`SNAP_W-1:0] snap,
                             input br_state_e st, input logic [`BR_MASK_W-1:0] dep);
    @(negedge clk);
    dispatch_br      = br;
    dispatch_snap    = snap;
    resolve_state    = st;
    resolve_dep_mask = dep;
  endtask

  // Resolve a recorded in-flight tag with its stored dependency mask
  task automatic resolve_tag(input int t, input br_state_e st, input logic br);
    drive_cycle(br, rng[7:0], st, chk.rec_dep[t]);
  endtask

  // Find a live tag with a record, random start, -1 if none
  function automatic int pick_tag(input logic [31:0] r);
    int idx;
    for (int i = 0; i < `BR_MASK_W; i++) begin
      idx = (int'(r % `BR_MASK_W) + i) % `BR_MASK_W;
      if (chk.m_mask[idx] && chk.rec_valid[idx]) return idx;
    end
    return -1;
  endfunction

  task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                           input logic [`WB_DAT_W-1:0] dat, output logic [`WB_DAT_W-1:0] q);
    int waited;
    @(negedge clk);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    waited  = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_ack && waited < ACK_LIMIT);
    if (!wb_ack) begin
      $display("Timeout: no Wishbone ack after %0d cycles", ACK_LIMIT);
      $display("Errors found");
      $finish;
    end else begin
      q = wb_rdat;
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic read_counters();
    wb_access(1'b0, REG_DISPATCH_CNT, '0, rd);
    chk.check_cnt("DISPATCH", 0, rd);
    wb_access(1'b0, REG_CORRECT_CNT, '0, rd);
    chk.check_cnt("CORRECT", 1, rd);
    wb_access(1'b0, REG_WRONG_CNT, '0, rd);
    chk.check_cnt("WRONG", 2, rd);
    wb_access(1'b0, REG_REFUSED_CNT, '0, rd);
    chk.check_cnt("REFUSED", 3, rd);
    wb_access(1'b0, REG_STATUS, '0, rd);
    chk.check_status(rd);
  endtask

  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    dispatch_br      = 1'b0;
    dispatch_snap    = '0;
    resolve_state    = BR_NONE;
    resolve_dep_mask = '0;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_wdat          = '0;
    rng              = 32'd3511;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    chk.start_test("alloc_order");
    for (int i = 0; i < 6; i++) begin // Sixth one finds the mask full
      rng = xorshift(rng);
      drive_cycle(1'b1, rng[7:0], BR_NONE, '0);
    end
    drive_cycle(1'b0, '0, BR_NONE, '0);
    chk.end_test();

    chk.start_test("correct_resolve");
    resolve_tag(2, BR_CORRECT, 1'b0);
    rng = xorshift(rng);
    resolve_tag(0, BR_CORRECT, 1'b1); // Freed tag 0 is granted again
    drive_cycle(1'b0, '0, BR_NONE, '0);
    chk.end_test();

    chk.start_test("wrong_resolve");
    resolve_tag(3, BR_WRONG, 1'b1);   // Dispatch ignored
    drive_cycle(1'b0, '0, BR_NONE, '0);
    drive_cycle(1'b0, '0, BR_NONE, '0);
    chk.end_test();

    chk.start_test("random_traffic");
    for (int n = 0; n < 300; n++) begin
      @(posedge clk); // Model takes the last drive before a tag is picked
      #1;
      rng = xorshift(rng);
      pick = (rng[10:8] < 3'd3) ? pick_tag(rng >> 12) : -1;
      if (pick < 0) begin
        drive_cycle(rng[0], rng[23:16], BR_NONE, '0);
      end else begin
        resolve_tag(pick, (rng[4] & rng[5]) ? BR_WRONG : BR_CORRECT, rng[0]);
      end
    end
    drive_cycle(1'b0, '0, BR_NONE, '0);
    chk.end_test();

    chk.start_test("counters");
    read_counters();
    chk.end_test();

    chk.start_test("clear");
    wb_access(1'b1, REG_CTRL, 32'd1, rd);
    read_counters(); // Model counts are zero, STATUS keeps the mask
    chk.end_test();

    chk.final_count();
    if (chk.err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/br_tag_pkg.sv
src/br_tag_if.sv
src/br_mask_ctrl.sv
src/br_checkpoint_store.sv
src/br_tag_regs.sv
src/br_tag_unit.sv
tb/br_tag_checker.sv
tb/tb_br_tag_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the branch tag unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_br_tag_unit \
  -f flist.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
